// File: hdl/deflate_sym_pkg.sv
// Symbol side of the fixed-table DEFLATE encoder
// Match length is limited to 3..64 and distance to 1..64
// Values outside these ranges are not encoded and must not be sent
package deflate_sym_pkg;

  //--------------------------------------------------
  // Input field widths
  //--------------------------------------------------
  localparam int unsigned LIT_DAT_WD = 8;
  // Wide enough to hold 64
  localparam int unsigned LEN_DAT_WD = 7;
  localparam int unsigned DIS_DAT_WD = 7;

  //--------------------------------------------------
  // Legal ranges
  //--------------------------------------------------
  localparam logic [LEN_DAT_WD-1:0] LEN_MIN = 7'd3;
  localparam logic [LEN_DAT_WD-1:0] LEN_MAX = 7'd64;
  localparam logic [DIS_DAT_WD-1:0] DIS_MIN = 7'd1;
  localparam logic [DIS_DAT_WD-1:0] DIS_MAX = 7'd64;

  // Kind of symbol on the input stream
  typedef enum logic [0:0] {
    OP_LITERAL = 1'b0,
    OP_MATCH   = 1'b1
  } sym_op_e;

endpackage

// File: hdl/deflate_code_pkg.sv
// Code side of the fixed-table DEFLATE encoder
// Codes are right-aligned, Huffman bits above the extra bits
// Extra bits are already bit-reversed, ready for an LSB-first packer
// No end-of-block symbol and no dynamic tables
package deflate_code_pkg;

  //--------------------------------------------------
  // Code widths
  //--------------------------------------------------
  localparam int unsigned LIT_CODE_WD = 9;
  // 7 Huffman bits + 3 extra bits
  localparam int unsigned LEN_CODE_WD = 10;
  // 5 Huffman bits + 4 extra bits
  localparam int unsigned DIS_CODE_WD = 9;

  localparam int unsigned LEN_HUFF_WD = 7;
  localparam int unsigned DIS_HUFF_WD = 5;

  // Full match word, length code above distance code
  localparam int unsigned CODE_WD = LEN_CODE_WD + DIS_CODE_WD;
  localparam int unsigned WIDTH_WD = 5;

  //--------------------------------------------------
  // Fixed literal table
  //--------------------------------------------------
  // Last literal with an 8-bit code
  localparam logic [7:0] LIT_SPLIT = 8'd143;
  // Code of literal 0
  localparam logic [LIT_CODE_WD-1:0] LIT_LO_BASE = 9'h030;
  // Code of literal 144
  localparam logic [LIT_CODE_WD-1:0] LIT_HI_BASE = 9'h190;

  typedef logic [CODE_WD-1:0]  code_t;
  typedef logic [WIDTH_WD-1:0] width_t;

endpackage

// File: hdl/lit_encoder.sv
// Fixed Huffman code of a literal byte
// Result updates only on advance_i, there is no valid bit here
// The packer keeps track of whether the result is live
module lit_encoder (
  input  logic                                    clk_i,
  input  logic                                    advance_i,
  input  logic [deflate_sym_pkg::LIT_DAT_WD-1:0]  lit_i,
  output logic [deflate_code_pkg::LIT_CODE_WD-1:0] lit_code_o,
  output deflate_code_pkg::width_t                lit_width_o
);

  logic [deflate_sym_pkg::LIT_DAT_WD-1:0]   lit_off;
  logic [deflate_code_pkg::LIT_CODE_WD-1:0] lit_code;
  deflate_code_pkg::width_t                 lit_width;

  // Offset into the upper table, starting at literal 144
  assign lit_off = lit_i - deflate_code_pkg::LIT_SPLIT - 8'd1;

  always_comb begin
    if (lit_i <= deflate_code_pkg::LIT_SPLIT) begin
      lit_code  = deflate_code_pkg::LIT_LO_BASE + {1'b0, lit_i};
      lit_width = deflate_code_pkg::width_t'(deflate_code_pkg::LIT_CODE_WD - 1);
    end else begin
      lit_code  = deflate_code_pkg::LIT_HI_BASE + {1'b0, lit_off};
      lit_width = deflate_code_pkg::width_t'(deflate_code_pkg::LIT_CODE_WD);
    end
  end

  //--------------------------------------------------
  // Stage 1 register
  //--------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      lit_code_o  <= lit_code;
      lit_width_o <= lit_width;
    end
  end

endmodule

// File: hdl/match_encoder.sv
// Fixed encoding of a length/distance pair
// Only length 3..64 and distance 1..64 give a valid code
// Extra bits come out reversed, below the Huffman bits
// Result updates only on advance_i
module match_encoder (
  input  logic                                     clk_i,
  input  logic                                     advance_i,
  input  logic [deflate_sym_pkg::LEN_DAT_WD-1:0]   len_i,
  input  logic [deflate_sym_pkg::DIS_DAT_WD-1:0]   dis_i,
  output logic [deflate_code_pkg::LEN_CODE_WD-1:0] len_code_o,
  output deflate_code_pkg::width_t                 len_width_o,
  output logic [deflate_code_pkg::DIS_CODE_WD-1:0] dis_code_o,
  output deflate_code_pkg::width_t                 dis_width_o
);

  logic [2:0]                                len_ext;
  logic [deflate_sym_pkg::LEN_DAT_WD-1:0]    len_base;
  logic [deflate_code_pkg::LEN_HUFF_WD-1:0]  len_start;
  logic [deflate_sym_pkg::LEN_DAT_WD-1:0]    len_off;
  logic [deflate_sym_pkg::LEN_DAT_WD-1:0]    len_shift;
  logic [deflate_code_pkg::LEN_HUFF_WD-1:0]  len_huff;
  logic [3:0]                                len_rev;
  logic [deflate_code_pkg::LEN_CODE_WD-1:0]  len_code;
  deflate_code_pkg::width_t                  len_width;

  logic [2:0]                                dis_ext;
  logic [deflate_sym_pkg::DIS_DAT_WD-1:0]    dis_base;
  logic [deflate_code_pkg::DIS_HUFF_WD-1:0]  dis_start;
  logic [deflate_sym_pkg::DIS_DAT_WD-1:0]    dis_off;
  logic [deflate_sym_pkg::DIS_DAT_WD-1:0]    dis_shift;
  logic [deflate_code_pkg::DIS_HUFF_WD-1:0]  dis_huff;
  logic [3:0]                                dis_rev;
  logic [deflate_code_pkg::DIS_CODE_WD-1:0]  dis_code;
  deflate_code_pkg::width_t                  dis_width;

  // Keep the low cnt bits and mirror them, left-aligned in 4 bits
  function automatic logic [3:0] rev_extra(input logic [3:0] off, input logic [2:0] cnt);
    logic [3:0] mask;
    logic [3:0] rev;
    mask = (4'b0001 << cnt) - 4'b0001;
    for (int i = 0; i < 4; i++) begin
      rev[i] = off[3-i] & mask[3-i];
    end
    return rev;
  endfunction

  //--------------------------------------------------
  // Length tiers
  //--------------------------------------------------
  always_comb begin
    if (len_i <= 7'd10) begin
      len_ext   = 3'd0;
      len_base  = deflate_sym_pkg::LEN_MIN;
      len_start = 7'd1;
    end else if (len_i <= 7'd18) begin
      len_ext   = 3'd1;
      len_base  = 7'd11;
      len_start = 7'd9;
    end else if (len_i <= 7'd34) begin
      len_ext   = 3'd2;
      len_base  = 7'd19;
      len_start = 7'd13;
    end else begin
      len_ext   = 3'd3;
      len_base  = 7'd35;
      len_start = 7'd17;
    end
  end

  assign len_off   = len_i - len_base;
  assign len_shift = len_off >> len_ext;
  assign len_huff  = len_start + len_shift;
  assign len_rev   = rev_extra({1'b0, len_off[2:0]}, len_ext);
  // Shifting the joined word right drops the unused extra positions
  assign len_code  = {len_huff, len_rev[3:1]} >> (3'd3 - len_ext);
  assign len_width = deflate_code_pkg::width_t'(deflate_code_pkg::LEN_HUFF_WD)
                   + deflate_code_pkg::width_t'(len_ext);

  //--------------------------------------------------
  // Distance tiers
  //--------------------------------------------------
  always_comb begin
    if (dis_i <= 7'd4) begin
      dis_ext   = 3'd0;
      dis_base  = deflate_sym_pkg::DIS_MIN;
      dis_start = 5'd0;
    end else if (dis_i <= 7'd8) begin
      dis_ext   = 3'd1;
      dis_base  = 7'd5;
      dis_start = 5'd4;
    end else if (dis_i <= 7'd16) begin
      dis_ext   = 3'd2;
      dis_base  = 7'd9;
      dis_start = 5'd6;
    end else if (dis_i <= 7'd32) begin
      dis_ext   = 3'd3;
      dis_base  = 7'd17;
      dis_start = 5'd8;
    end else begin
      dis_ext   = 3'd4;
      dis_base  = 7'd33;
      dis_start = 5'd10;
    end
  end

  assign dis_off   = dis_i - dis_base;
  assign dis_shift = dis_off >> dis_ext;
  assign dis_huff  = dis_start + dis_shift[deflate_code_pkg::DIS_HUFF_WD-1:0];
  assign dis_rev   = rev_extra(dis_off[3:0], dis_ext);
  assign dis_code  = {dis_huff, dis_rev} >> (3'd4 - dis_ext);
  assign dis_width = deflate_code_pkg::width_t'(deflate_code_pkg::DIS_HUFF_WD)
                   + deflate_code_pkg::width_t'(dis_ext);

  // Stage 1 register
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      len_code_o  <= len_code;
      len_width_o <= len_width;
      dis_code_o  <= dis_code;
      dis_width_o <= dis_width;
    end
  end

endmodule

// File: hdl/code_packer.sv
// Pipeline control and output packing
// Stage 1 is this valid/op pair plus the encoder registers
// Stage 2 is the output register, held while out_ready_i is low
// A match word is the length code above the distance code
module code_packer (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     in_valid_i,
  input  deflate_sym_pkg::sym_op_e                 in_op_i,
  output logic                                     in_ready_o,
  output logic                                     advance_o,
  input  logic [deflate_code_pkg::LIT_CODE_WD-1:0] lit_code_i,
  input  deflate_code_pkg::width_t                 lit_width_i,
  input  logic [deflate_code_pkg::LEN_CODE_WD-1:0] len_code_i,
  input  deflate_code_pkg::width_t                 len_width_i,
  input  logic [deflate_code_pkg::DIS_CODE_WD-1:0] dis_code_i,
  input  deflate_code_pkg::width_t                 dis_width_i,
  input  logic                                     out_ready_i,
  output logic                                     out_valid_o,
  output deflate_code_pkg::code_t                  code_o,
  output deflate_code_pkg::width_t                 width_o
);

  logic                     s1_valid_q;
  deflate_sym_pkg::sym_op_e s1_op_q;
  logic                     s2_valid_q;
  deflate_code_pkg::code_t  s2_code_q;
  deflate_code_pkg::width_t s2_width_q;

  logic                     advance;
  deflate_code_pkg::code_t  pack_code;
  deflate_code_pkg::width_t pack_width;

  // Stage 1 may move when it is empty or stage 2 can take it
  assign advance    = !s2_valid_q || out_ready_i || !s1_valid_q;
  assign advance_o  = advance;
  assign in_ready_o = advance;

  always_comb begin
    case (s1_op_q)
      deflate_sym_pkg::OP_MATCH: begin
        pack_code  = (deflate_code_pkg::code_t'(len_code_i) << dis_width_i)
                   | deflate_code_pkg::code_t'(dis_code_i);
        pack_width = len_width_i + dis_width_i;
      end
      default: begin
        pack_code  = deflate_code_pkg::code_t'(lit_code_i);
        pack_width = lit_width_i;
      end
    endcase
  end

  //--------------------------------------------------
  // Stage 1 valid and op
  //--------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_op_q <= in_op_i;
    end
  end

  //--------------------------------------------------
  // Stage 2 output register
  //--------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s2_valid_q <= 1'b0;
    end else if (s1_valid_q && advance) begin
      s2_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      s2_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q && advance) begin
      s2_code_q  <= pack_code;
      s2_width_q <= pack_width;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign code_o      = s2_code_q;
  assign width_o     = s2_width_q;

endmodule

// File: hdl/huffman_fixed.sv
// Fixed-table DEFLATE symbol encoder with valid/ready on both sides
// Two cycles from input transfer to output valid, one symbol per cycle
// Output is one right-aligned code word and its width, no byte packing
module huffman_fixed (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  deflate_sym_pkg::sym_op_e               in_op_i,
  input  logic [deflate_sym_pkg::LIT_DAT_WD-1:0] lit_i,
  input  logic [deflate_sym_pkg::LEN_DAT_WD-1:0] len_i,
  input  logic [deflate_sym_pkg::DIS_DAT_WD-1:0] dis_i,
  input  logic                                   out_ready_i,
  output logic                                   out_valid_o,
  output deflate_code_pkg::code_t                code_o,
  output deflate_code_pkg::width_t               width_o
);

  logic                                     advance;
  logic [deflate_code_pkg::LIT_CODE_WD-1:0] lit_code;
  deflate_code_pkg::width_t                 lit_width;
  logic [deflate_code_pkg::LEN_CODE_WD-1:0] len_code;
  deflate_code_pkg::width_t                 len_width;
  logic [deflate_code_pkg::DIS_CODE_WD-1:0] dis_code;
  deflate_code_pkg::width_t                 dis_width;

  lit_encoder u_lit_encoder (
    .clk_i       (clk_i),
    .advance_i   (advance),
    .lit_i       (lit_i),
    .lit_code_o  (lit_code),
    .lit_width_o (lit_width)
  );

  match_encoder u_match_encoder (
    .clk_i       (clk_i),
    .advance_i   (advance),
    .len_i       (len_i),
    .dis_i       (dis_i),
    .len_code_o  (len_code),
    .len_width_o (len_width),
    .dis_code_o  (dis_code),
    .dis_width_o (dis_width)
  );

  // Owns the handshake and the output register
  code_packer u_code_packer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_op_i     (in_op_i),
    .in_ready_o  (in_ready_o),
    .advance_o   (advance),
    .lit_code_i  (lit_code),
    .lit_width_i (lit_width),
    .len_code_i  (len_code),
    .len_width_i (len_width),
    .dis_code_i  (dis_code),
    .dis_width_i (dis_width),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .code_o      (code_o),
    .width_o     (width_o)
  );

endmodule

// File: dv/tb_clk_gen.sv
// Testbench clock and reset source
// Clock period is 10 time units
// Reset is held low for 16 rising edges, released 1 unit after the last
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: dv/tb_huffman_fixed.sv
// Table-driven testbench for huffman_fixed
// Expected codes come from a model of the fixed-table tier rules
// out_ready_i is random until the last section, which runs at full rate
// Only legal lengths 3..64 and distances 1..64 are driven
module tb_huffman_fixed;

  localparam int N_LIT     = 256;
  localparam int N_LEN     = 62;
  localparam int N_DIS     = 64;
  localparam int N_MIX     = 48;
  localparam int N_RUN     = 24;
  localparam int RUN_START = N_LIT + N_LEN + N_DIS + N_MIX;
  localparam int N_TAB     = RUN_START + N_RUN;
  localparam int CYC_LIMIT = 16 + 8 * N_TAB + 50;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic                                   in_valid_i;
  logic                                   in_ready_o;
  deflate_sym_pkg::sym_op_e               in_op_i;
  logic [deflate_sym_pkg::LIT_DAT_WD-1:0] lit_i;
  logic [deflate_sym_pkg::LEN_DAT_WD-1:0] len_i;
  logic [deflate_sym_pkg::DIS_DAT_WD-1:0] dis_i;
  logic                                   out_ready_i;
  logic                                   out_valid_o;
  deflate_code_pkg::code_t                code_o;
  deflate_code_pkg::width_t               width_o;

  // Stimulus and expected values
  deflate_sym_pkg::sym_op_e               tab_op    [N_TAB];
  logic [deflate_sym_pkg::LIT_DAT_WD-1:0] tab_lit   [N_TAB];
  logic [deflate_sym_pkg::LEN_DAT_WD-1:0] tab_len   [N_TAB];
  logic [deflate_sym_pkg::DIS_DAT_WD-1:0] tab_dis   [N_TAB];
  deflate_code_pkg::code_t                tab_code  [N_TAB];
  deflate_code_pkg::width_t               tab_width [N_TAB];
  string                                  tab_name  [N_TAB];
  int                                     in_cyc    [N_TAB];

  integer seed;
  logic   full_rate;
  int     cycle_cnt;
  int     out_cnt;
  int     code_errs;
  int     width_errs;
  int     proto_errs;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  huffman_fixed dut_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_op_i     (in_op_i),
    .lit_i       (lit_i),
    .len_i       (len_i),
    .dis_i       (dis_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .code_o      (code_o),
    .width_o     (width_o)
  );

  //--------------------------------------------------
  // Reference model
  //--------------------------------------------------
  function automatic int reverse_bits(input int val, input int cnt);
    int res;
    res = 0;
    for (int b = 0; b < cnt; b++) begin
      res = (res << 1) | ((val >> b) & 1);
    end
    return res;
  endfunction

  function automatic void length_code(input int len, output int code, output int wd);
    int ext;
    int base;
    int start;
    int off;
    ext   = (len <= 10) ? 0 : (len <= 18) ? 1 : (len <= 34) ? 2 : 3;
    base  = (ext == 0) ? 3 : (ext == 1) ? 11 : (ext == 2) ? 19 : 35;
    start = (ext == 0) ? 1 : (ext == 1) ? 9 : (ext == 2) ? 13 : 17;
    off   = len - base;
    code  = ((start + (off >> ext)) << ext) | reverse_bits(off, ext);
    wd    = int'(deflate_code_pkg::LEN_HUFF_WD) + ext;
  endfunction

  function automatic void distance_code(input int dis, output int code, output int wd);
    int ext;
    int base;
    int start;
    int off;
    ext   = (dis <= 4) ? 0 : (dis <= 8) ? 1 : (dis <= 16) ? 2 : (dis <= 32) ? 3 : 4;
    base  = (ext == 0) ? 1 : (ext == 1) ? 5 : (ext == 2) ? 9 : (ext == 3) ? 17 : 33;
    start = (ext == 0) ? 0 : (ext == 1) ? 4 : (ext == 2) ? 6 : (ext == 3) ? 8 : 10;
    off   = dis - base;
    code  = ((start + (off >> ext)) << ext) | reverse_bits(off, ext);
    wd    = int'(deflate_code_pkg::DIS_HUFF_WD) + ext;
  endfunction

  function automatic void model_symbol(input deflate_sym_pkg::sym_op_e op, input int lit,
                                       input int len, input int dis,
                                       output deflate_code_pkg::code_t code,
                                       output deflate_code_pkg::width_t wd);
    int lc;
    int lw;
    int dc;
    int dw;
    if (op == deflate_sym_pkg::OP_LITERAL) begin
      if (lit <= int'(deflate_code_pkg::LIT_SPLIT)) begin
        lc = int'(deflate_code_pkg::LIT_LO_BASE) + lit;
        lw = 8;
      end else begin
        lc = int'(deflate_code_pkg::LIT_HI_BASE) + lit - 144;
        lw = 9;
      end
    end else begin
      length_code(len, lc, lw);
      distance_code(dis, dc, dw);
      // Length code sits above the distance code
      lc = (lc << dw) | dc;
      lw = lw + dw;
    end
    code = deflate_code_pkg::code_t'(lc);
    wd   = deflate_code_pkg::width_t'(lw);
  endfunction

  task automatic build_table();
    int lit;
    int len;
    int dis;
    deflate_sym_pkg::sym_op_e op;
    for (int k = 0; k < N_TAB; k++) begin
      op  = deflate_sym_pkg::OP_MATCH;
      lit = 0;
      len = 3;
      dis = 1;
      if (k < N_LIT) begin
        op  = deflate_sym_pkg::OP_LITERAL;
        lit = k;
        tab_name[k] = $sformatf("literal %0d", lit);
      end else if (k < N_LIT + N_LEN) begin
        len = k - N_LIT + 3;
        tab_name[k] = $sformatf("length %0d", len);
      end else if (k < N_LIT + N_LEN + N_DIS) begin
        dis = k - N_LIT - N_LEN + 1;
        tab_name[k] = $sformatf("distance %0d", dis);
      end else begin
        op  = ($random(seed) & 1) ? deflate_sym_pkg::OP_MATCH : deflate_sym_pkg::OP_LITERAL;
        lit = int'($unsigned($random(seed)) % 256);
        len = 3 + int'($unsigned($random(seed)) % 62);
        dis = 1 + int'($unsigned($random(seed)) % 64);
        tab_name[k] = $sformatf("%s %0d", (k < RUN_START) ? "mix" : "stream", k);
      end
      tab_op[k]  = op;
      tab_lit[k] = 8'(lit);
      tab_len[k] = 7'(len);
      tab_dis[k] = 7'(dis);
      model_symbol(op, lit, len, dis, tab_code[k], tab_width[k]);
    end
  endtask

  //--------------------------------------------------
  // Checks
  //--------------------------------------------------
  task automatic check_code(input string name, input deflate_code_pkg::code_t exp,
                            input deflate_code_pkg::code_t act);
    if (act !== exp) begin
      $display("Error %s code: expected %h, actual %h", name, exp, act);
      code_errs++;
    end
  endtask

  task automatic check_width(input string name, input deflate_code_pkg::width_t exp,
                             input deflate_code_pkg::width_t act);
    if (act !== exp) begin
      $display("Error %s width: expected %0d, actual %0d", name, exp, act);
      width_errs++;
    end
  endtask

  task automatic check_idle(input string when);
    if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("Pipeline not idle %s: out_valid_o should be low and in_ready_o high, got %b %b",
               when, out_valid_o, in_ready_o);
      proto_errs++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    out_ready_i = full_rate ? 1'b1 : 1'($random(seed));
  endtask

  //--------------------------------------------------
  // Stimulus
  //--------------------------------------------------
  initial begin : drive_inputs
    seed        = 32'h967ef1fc;
    full_rate   = 1'b0;
    in_valid_i  = 1'b0;
    in_op_i     = deflate_sym_pkg::OP_LITERAL;
    lit_i       = '0;
    len_i       = deflate_sym_pkg::LEN_MIN;
    dis_i       = deflate_sym_pkg::DIS_MIN;
    out_ready_i = 1'b0;
    out_cnt     = 0;
    code_errs   = 0;
    width_errs  = 0;
    proto_errs  = 0;
    build_table();

    // First reset edge clears both valid bits
    @(posedge clk_i);
    while (rst_n_i !== 1'b1) begin
      @(negedge clk_i);
      check_idle("during reset");
    end
    @(negedge clk_i);
    check_idle("after reset");

    for (int i = 0; i < N_TAB; i++) begin
      if (i == RUN_START) begin
        full_rate = 1'b1;
      end
      next_cycle();
      in_valid_i = 1'b1;
      in_op_i    = tab_op[i];
      lit_i      = tab_lit[i];
      len_i      = tab_len[i];
      dis_i      = tab_dis[i];
      @(negedge clk_i);
      while (!in_ready_o) begin
        if (full_rate) begin
          $display("Input %s was stalled although out_ready_i is held high", tab_name[i]);
          proto_errs++;
        end
        next_cycle();
        @(negedge clk_i);
      end
      in_cyc[i] = cycle_cnt;
    end
    next_cycle();
    in_valid_i = 1'b0;

    // Drain, then a few idle cycles to catch extra outputs
    while (out_cnt < N_TAB) begin
      next_cycle();
    end
    repeat (4) next_cycle();

    $display("Errors: code %0d, width %0d, protocol %0d", code_errs, width_errs, proto_errs);
    if (code_errs + width_errs + proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  //--------------------------------------------------
  // Output collection, in input order
  //--------------------------------------------------
  initial begin : collect_outputs
    logic                     stalled;
    deflate_code_pkg::code_t  held_code;
    deflate_code_pkg::width_t held_width;
    stalled    = 1'b0;
    held_code  = '0;
    held_width = '0;
    wait (rst_n_i === 1'b1);
    forever begin
      @(negedge clk_i);
      if (stalled && out_valid_o !== 1'b1) begin
        $display("out_valid_o dropped while output %0d was stalled", out_cnt);
        proto_errs++;
      end else if (stalled) begin
        check_code($sformatf("output %0d held", out_cnt), held_code, code_o);
        check_width($sformatf("output %0d held", out_cnt), held_width, width_o);
      end
      stalled    = out_valid_o && !out_ready_i;
      held_code  = code_o;
      held_width = width_o;
      if (out_valid_o && out_ready_i) begin
        if (out_cnt >= N_TAB) begin
          $display("Extra output appeared after all %0d symbols were received", N_TAB);
          proto_errs++;
        end else begin
          check_code(tab_name[out_cnt], tab_code[out_cnt], code_o);
          check_width(tab_name[out_cnt], tab_width[out_cnt], width_o);
          if (out_cnt >= RUN_START && cycle_cnt - in_cyc[out_cnt] != 2) begin
            $display("Latency of %s was %0d cycles instead of 2", tab_name[out_cnt],
                     cycle_cnt - in_cyc[out_cnt]);
            proto_errs++;
          end
          out_cnt++;
        end
      end
    end
  end

  // Cycle limit
  initial begin : watch_cycles
    cycle_cnt = 0;
    while (cycle_cnt < CYC_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d of %0d outputs received",
             cycle_cnt, out_cnt, N_TAB);
    $display("Errors: code %0d, width %0d, protocol %0d", code_errs, width_errs, proto_errs);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: huffman_fixed.f
hdl/deflate_sym_pkg.sv
hdl/deflate_code_pkg.sv
hdl/lit_encoder.sv
hdl/match_encoder.sv
hdl/code_packer.sv
hdl/huffman_fixed.sv
dv/tb_clk_gen.sv
dv/tb_huffman_fixed.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the huffman_fixed testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_huffman_fixed \
  -Mdir obj_dir -f huffman_fixed.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_huffman_fixed > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "No result found in $LOG"
  exit 1
fi
exit 0
